/* src/soc_pkg.sv */
// Shared widths, address map, response codes and channel types for the SoC bus.
// Every other source file refers to these by scoped name.
`default_nettype none

package soc_pkg;

    // bus widths
    localparam int ADDR_W = 64;
    localparam int DATA_W = 64;
    localparam int STRB_W = 8;

    // address map
    localparam logic [ADDR_W-1:0] RAM_BASE   = 64'h0000_0000_8000_0000;
    localparam logic [ADDR_W-1:0] RAM_SIZE   = 64'h0000_0000_0800_0000;
    localparam logic [ADDR_W-1:0] CLINT_BASE = 64'h0000_0000_0200_0000;
    localparam logic [ADDR_W-1:0] CLINT_SIZE = 64'h0000_0000_0001_0000;

    // register offsets inside the CLINT window
    localparam logic [ADDR_W-1:0] MTIMECMP_OFS = 64'h0000_0000_0000_4000;
    localparam logic [ADDR_W-1:0] MTIME_OFS    = 64'h0000_0000_0000_bff8;

    // AXI response codes
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;
    localparam logic [1:0] RESP_DECERR = 2'b11;

    typedef enum logic [1:0] {
        TGT_RAM,
        TGT_CLINT,
        TGT_NONE
    } target_e;

    typedef enum logic {
        OP_READ,
        OP_WRITE
    } op_e;

    // AXI4-Lite channel payloads
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
    } axi_aw_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
    } axi_w_t;

    typedef struct packed {
        logic [1:0] resp;
    } axi_b_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
    } axi_ar_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [1:0]        resp;
    } axi_r_t;

    // decoded request, addr is the offset inside the target window
    typedef struct packed {
        logic              valid;
        op_e               op;
        target_e           target;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        logic [STRB_W-1:0] strb;
    } tgt_req_t;

    typedef struct packed {
        logic              valid;
        logic [DATA_W-1:0] rdata;
        logic              err;
    } tgt_rsp_t;

endpackage

`default_nettype wire

/* src/soc_addr_decode.sv */
// Front end of the interconnect. Accepts one AXI4-Lite read or write at a time,
// picks the target window and issues a single-cycle decoded request.
`timescale 1ns/10ps
`default_nettype none

module soc_addr_decode (
    input  wire                     clk,
    input  wire                     i_rst_n,
    input  wire soc_pkg::axi_aw_t   i_aw,
    input  wire                     i_aw_valid,
    input  wire soc_pkg::axi_w_t    i_w,
    input  wire                     i_w_valid,
    input  wire soc_pkg::axi_ar_t   i_ar,
    input  wire                     i_ar_valid,
    input  wire                     i_done,
    output logic                    o_aw_ready,
    output logic                    o_w_ready,
    output logic                    o_ar_ready,
    output soc_pkg::tgt_req_t       o_req
);

    typedef enum logic {
        DEC_IDLE,
        DEC_BUSY
    } dec_state_e;

    dec_state_e                     state;
    logic                           wr_acc;
    logic                           rd_acc;
    logic [soc_pkg::ADDR_W-1:0]     acc_addr;
    soc_pkg::target_e               acc_tgt;
    logic [soc_pkg::ADDR_W-1:0]     acc_ofs;

    logic                           req_valid;
    soc_pkg::op_e                   req_op;
    soc_pkg::target_e               req_tgt;
    logic [soc_pkg::ADDR_W-1:0]     req_addr;
    logic [soc_pkg::DATA_W-1:0]     req_wdata;
    logic [soc_pkg::STRB_W-1:0]     req_strb;

    // writes win a tie, a read waits while either write channel is valid
    assign wr_acc   = (state == DEC_IDLE) && i_aw_valid && i_w_valid;
    assign rd_acc   = (state == DEC_IDLE) && i_ar_valid && !i_aw_valid && !i_w_valid;
    assign acc_addr = wr_acc ? i_aw.addr : i_ar.addr;

    always_comb begin
        if (acc_addr >= soc_pkg::RAM_BASE &&
            acc_addr < soc_pkg::RAM_BASE + soc_pkg::RAM_SIZE) begin
            acc_tgt = soc_pkg::TGT_RAM;
            acc_ofs = acc_addr - soc_pkg::RAM_BASE;
        end else if (acc_addr >= soc_pkg::CLINT_BASE &&
                     acc_addr < soc_pkg::CLINT_BASE + soc_pkg::CLINT_SIZE) begin
            acc_tgt = soc_pkg::TGT_CLINT;
            acc_ofs = acc_addr - soc_pkg::CLINT_BASE;
        end else begin
            acc_tgt = soc_pkg::TGT_NONE;
            acc_ofs = acc_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            state     <= DEC_IDLE;
            req_valid <= 1'b0;
        end else begin
            req_valid <= wr_acc || rd_acc;
            if (wr_acc || rd_acc)
                state <= DEC_BUSY;
            else if (i_done)
                state <= DEC_IDLE;
        end
    end

    // request payload, qualified by req_valid
    always_ff @(posedge clk) begin
        if (wr_acc || rd_acc) begin
            req_op    <= wr_acc ? soc_pkg::OP_WRITE : soc_pkg::OP_READ;
            req_tgt   <= acc_tgt;
            req_addr  <= acc_ofs;
            req_wdata <= i_w.data;
            req_strb  <= wr_acc ? i_w.strb : '0;
        end
    end

    assign o_aw_ready = wr_acc;
    assign o_w_ready  = wr_acc;
    assign o_ar_ready = rd_acc;
    assign o_req = '{valid: req_valid, op: req_op, target: req_tgt,
                     addr: req_addr, wdata: req_wdata, strb: req_strb};

    // only the first busy cycle may carry a request
    a_no_req_busy: assert property (@(posedge clk) disable iff (!i_rst_n)
        (state == DEC_BUSY) && $past(state == DEC_BUSY) |-> !o_req.valid);

endmodule

`default_nettype wire

/* src/clint_timer.sv */
// Machine timer behind the interconnect. Holds mtime and mtimecmp, answers
// decoded requests one cycle later and raises the timer interrupt.
`timescale 1ns/10ps
`default_nettype none

module clint_timer (
    input  wire                     clk,
    input  wire                     i_rst_n,
    input  wire soc_pkg::tgt_req_t  i_req,
    output soc_pkg::tgt_rsp_t       o_rsp,
    output logic                    o_timer_irq
);

    logic [soc_pkg::DATA_W-1:0]     mtime;
    logic [soc_pkg::DATA_W-1:0]     mtimecmp;
    logic                           hit;
    logic                           wr_hit;
    logic                           is_mtime;
    logic                           is_cmp;

    logic                           rsp_valid;
    logic [soc_pkg::DATA_W-1:0]     rsp_data;
    logic                           rsp_err;

    // byte lane merge of a write into a 64-bit register
    function automatic logic [soc_pkg::DATA_W-1:0] merge_bytes(
        input logic [soc_pkg::DATA_W-1:0] old_val,
        input logic [soc_pkg::DATA_W-1:0] wdata,
        input logic [soc_pkg::STRB_W-1:0] strb
    );
        logic [soc_pkg::DATA_W-1:0] res;
        res = old_val;
        for (int i = 0; i < soc_pkg::STRB_W; i++) begin
            if (strb[i])
                res[i*8 +: 8] = wdata[i*8 +: 8];
        end
        return res;
    endfunction

    assign hit      = i_req.valid && (i_req.target == soc_pkg::TGT_CLINT);
    assign wr_hit   = hit && (i_req.op == soc_pkg::OP_WRITE);
    assign is_mtime = (i_req.addr == soc_pkg::MTIME_OFS);
    assign is_cmp   = (i_req.addr == soc_pkg::MTIMECMP_OFS);

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            mtime       <= '0;
            mtimecmp    <= '1;
            o_timer_irq <= 1'b0;
            rsp_valid   <= 1'b0;
        end else begin
            // a write to mtime replaces this cycle's increment
            if (wr_hit && is_mtime)
                mtime <= merge_bytes(mtime, i_req.wdata, i_req.strb);
            else
                mtime <= mtime + 1'b1;
            if (wr_hit && is_cmp)
                mtimecmp <= merge_bytes(mtimecmp, i_req.wdata, i_req.strb);
            o_timer_irq <= (mtime >= mtimecmp);
            rsp_valid   <= hit;
        end
    end

    always_ff @(posedge clk) begin
        if (hit) begin
            if (i_req.op == soc_pkg::OP_READ && is_mtime)
                rsp_data <= mtime;
            else if (i_req.op == soc_pkg::OP_READ && is_cmp)
                rsp_data <= mtimecmp;
            else
                rsp_data <= '0;
            // unknown offset, read or write
            rsp_err <= !(is_mtime || is_cmp);
        end
    end

    assign o_rsp = '{valid: rsp_valid, rdata: rsp_data, err: rsp_err};

endmodule

`default_nettype wire

/* src/ram_port_bridge.sv */
// Bridge from decoded requests to the external RAM port. The RAM strobes follow
// the request cycle and read data comes back in the same cycle.
`timescale 1ns/10ps
`default_nettype none

module ram_port_bridge (
    input  wire                             clk,
    input  wire                             i_rst_n,
    input  wire soc_pkg::tgt_req_t          i_req,
    input  wire [soc_pkg::DATA_W-1:0]       i_ram_rdata,
    output soc_pkg::tgt_rsp_t               o_rsp,
    output logic                            o_ram_rd_en,
    output logic [soc_pkg::ADDR_W-1:0]      o_ram_addr,
    output logic                            o_ram_wr_en,
    output logic [soc_pkg::ADDR_W-1:0]      o_ram_waddr,
    output logic [soc_pkg::DATA_W-1:0]      o_ram_wdata,
    output logic [soc_pkg::STRB_W-1:0]      o_ram_wmask
);

    logic                           hit;
    logic [soc_pkg::ADDR_W-1:0]     bus_addr;

    logic                           rsp_valid;
    logic [soc_pkg::DATA_W-1:0]     rsp_data;

    assign hit = i_req.valid && (i_req.target == soc_pkg::TGT_RAM);

    // put the window base back onto the offset
    assign bus_addr = soc_pkg::RAM_BASE + i_req.addr;

    assign o_ram_rd_en = hit && (i_req.op == soc_pkg::OP_READ);
    assign o_ram_wr_en = hit && (i_req.op == soc_pkg::OP_WRITE);
    assign o_ram_addr  = bus_addr;
    assign o_ram_waddr = bus_addr;
    assign o_ram_wdata = i_req.wdata;
    assign o_ram_wmask = i_req.strb;

    always_ff @(posedge clk) begin
        if (!i_rst_n)
            rsp_valid <= 1'b0;
        else
            rsp_valid <= hit;
    end

    // capture read data, writes reply with zero
    always_ff @(posedge clk) begin
        if (hit)
            rsp_data <= o_ram_rd_en ? i_ram_rdata : '0;
    end

    assign o_rsp = '{valid: rsp_valid, rdata: rsp_data, err: 1'b0};

    a_rd_wr_excl: assert property (@(posedge clk) disable iff (!i_rst_n)
        !(o_ram_rd_en && o_ram_wr_en));

    // strobes are single cycle pulses
    a_strobe_pulse: assert property (@(posedge clk) disable iff (!i_rst_n)
        (o_ram_rd_en || o_ram_wr_en) |=> !(o_ram_rd_en || o_ram_wr_en));

endmodule

`default_nettype wire

/* src/soc_resp_mux.sv */
// Result stage of the interconnect. Picks the reply of the addressed target,
// forms the B or R response and holds it until the master takes it.
`timescale 1ns/10ps
`default_nettype none

module soc_resp_mux (
    input  wire                     clk,
    input  wire                     i_rst_n,
    input  wire soc_pkg::tgt_req_t  i_req,
    input  wire soc_pkg::tgt_rsp_t  i_clint_rsp,
    input  wire soc_pkg::tgt_rsp_t  i_ram_rsp,
    input  wire                     i_b_ready,
    input  wire                     i_r_ready,
    output soc_pkg::axi_b_t         o_b,
    output logic                    o_b_valid,
    output soc_pkg::axi_r_t         o_r,
    output logic                    o_r_valid,
    output logic                    o_done
);

    soc_pkg::op_e                   op_q;
    soc_pkg::target_e               tgt_q;
    logic                           none_q;
    soc_pkg::tgt_rsp_t              sel;
    logic                           fire;
    logic [1:0]                     resp;

    logic [1:0]                     b_resp;
    logic [soc_pkg::DATA_W-1:0]     r_data;
    logic [1:0]                     r_resp;

    always_comb begin
        case (tgt_q)
            soc_pkg::TGT_RAM:   sel = i_ram_rsp;
            soc_pkg::TGT_CLINT: sel = i_clint_rsp;
            default:            sel = '0;
        endcase
    end

    // unmapped requests get no target reply, none_q stands in for one
    assign fire = sel.valid || none_q;
    assign resp = none_q  ? soc_pkg::RESP_DECERR :
                  sel.err ? soc_pkg::RESP_SLVERR : soc_pkg::RESP_OKAY;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            op_q      <= soc_pkg::OP_READ;
            tgt_q     <= soc_pkg::TGT_NONE;
            none_q    <= 1'b0;
            o_b_valid <= 1'b0;
            o_r_valid <= 1'b0;
        end else begin
            if (i_req.valid) begin
                op_q  <= i_req.op;
                tgt_q <= i_req.target;
            end
            none_q <= i_req.valid && (i_req.target == soc_pkg::TGT_NONE);
            if (fire && op_q == soc_pkg::OP_WRITE)
                o_b_valid <= 1'b1;
            else if (i_b_ready)
                o_b_valid <= 1'b0;
            if (fire && op_q == soc_pkg::OP_READ)
                o_r_valid <= 1'b1;
            else if (i_r_ready)
                o_r_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            b_resp <= resp;
            r_resp <= resp;
            r_data <= none_q ? '0 : sel.rdata;
        end
    end

    assign o_b    = '{resp: b_resp};
    assign o_r    = '{data: r_data, resp: r_resp};
    assign o_done = (o_b_valid && i_b_ready) || (o_r_valid && i_r_ready);

    a_b_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_b_valid && !i_b_ready |=> o_b_valid && $stable(o_b));

    a_r_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_r_valid && !i_r_ready |=> o_r_valid && $stable(o_r));

endmodule

`default_nettype wire

/* src/soc_top.sv */
// Memory-mapped side of the SoC. One AXI4-Lite slave port in front of the
// address decoder, the machine timer, the RAM port bridge and the response stage.
`timescale 1ns/10ps
`default_nettype none

module soc_top (
    input  wire                             clk,
    input  wire                             i_rst_n,
    input  wire soc_pkg::axi_aw_t           i_aw,
    input  wire                             i_aw_valid,
    output logic                            o_aw_ready,
    input  wire soc_pkg::axi_w_t            i_w,
    input  wire                             i_w_valid,
    output logic                            o_w_ready,
    output soc_pkg::axi_b_t                 o_b,
    output logic                            o_b_valid,
    input  wire                             i_b_ready,
    input  wire soc_pkg::axi_ar_t           i_ar,
    input  wire                             i_ar_valid,
    output logic                            o_ar_ready,
    output soc_pkg::axi_r_t                 o_r,
    output logic                            o_r_valid,
    input  wire                             i_r_ready,
    output logic                            o_ram_rd_en,
    output logic [soc_pkg::ADDR_W-1:0]      o_ram_addr,
    input  wire  [soc_pkg::DATA_W-1:0]      i_ram_rdata,
    output logic                            o_ram_wr_en,
    output logic [soc_pkg::ADDR_W-1:0]      o_ram_waddr,
    output logic [soc_pkg::DATA_W-1:0]      o_ram_wdata,
    output logic [soc_pkg::STRB_W-1:0]      o_ram_wmask,
    output logic                            o_timer_irq
);

    soc_pkg::tgt_req_t  req;
    soc_pkg::tgt_rsp_t  clint_rsp;
    soc_pkg::tgt_rsp_t  ram_rsp;
    logic               done;

    soc_addr_decode i_decode (
        .clk(clk), .i_rst_n(i_rst_n),
        .i_aw(i_aw), .i_aw_valid(i_aw_valid), .i_w(i_w), .i_w_valid(i_w_valid),
        .i_ar(i_ar), .i_ar_valid(i_ar_valid), .i_done(done),
        .o_aw_ready(o_aw_ready), .o_w_ready(o_w_ready), .o_ar_ready(o_ar_ready),
        .o_req(req)
    );

    clint_timer i_clint (
        .clk(clk), .i_rst_n(i_rst_n), .i_req(req),
        .o_rsp(clint_rsp), .o_timer_irq(o_timer_irq)
    );

    ram_port_bridge i_ram (
        .clk(clk), .i_rst_n(i_rst_n), .i_req(req), .i_ram_rdata(i_ram_rdata),
        .o_rsp(ram_rsp), .o_ram_rd_en(o_ram_rd_en), .o_ram_addr(o_ram_addr),
        .o_ram_wr_en(o_ram_wr_en), .o_ram_waddr(o_ram_waddr),
        .o_ram_wdata(o_ram_wdata), .o_ram_wmask(o_ram_wmask)
    );

    soc_resp_mux i_resp (
        .clk(clk), .i_rst_n(i_rst_n), .i_req(req),
        .i_clint_rsp(clint_rsp), .i_ram_rsp(ram_rsp),
        .i_b_ready(i_b_ready), .i_r_ready(i_r_ready),
        .o_b(o_b), .o_b_valid(o_b_valid), .o_r(o_r), .o_r_valid(o_r_valid),
        .o_done(done)
    );

endmodule

`default_nettype wire

/* tb/tb_soc_top.sv */
// Testbench for soc_top. Acts as the AXI4-Lite master, models the external RAM
// and checks the bus with assertions while directed and random traffic runs.
`timescale 1ns/10ps
`default_nettype none

module tb_soc_top;

    localparam int TMO = 500;

    logic clk;
    logic i_rst_n;
    soc_pkg::axi_aw_t aw;
    soc_pkg::axi_w_t w;
    soc_pkg::axi_ar_t ar;
    logic aw_valid, w_valid, ar_valid, b_ready, r_ready;
    logic o_aw_ready, o_w_ready, o_ar_ready, o_b_valid, o_r_valid;
    soc_pkg::axi_b_t o_b;
    soc_pkg::axi_r_t o_r;
    logic o_ram_rd_en, o_ram_wr_en, o_timer_irq;
    logic [63:0] o_ram_addr, o_ram_waddr, o_ram_wdata, i_ram_rdata;
    logic [7:0] o_ram_wmask;

    // ram model of 256 tagged words
    logic [63:0] mem [0:255];
    logic [63:0] tag [0:255];
    logic [255:0] tag_ok;

    logic [31:0] lfsr;
    int errors;
    int tests;
    int failed;
    int wr_pulses;
    int rd_pulses;
    logic [63:0] exp_addr, exp_data;
    logic [7:0] exp_strb;
    logic no_ram;

    soc_top i_dut (
        .clk(clk), .i_rst_n(i_rst_n),
        .i_aw(aw), .i_aw_valid(aw_valid), .o_aw_ready(o_aw_ready),
        .i_w(w), .i_w_valid(w_valid), .o_w_ready(o_w_ready),
        .o_b(o_b), .o_b_valid(o_b_valid), .i_b_ready(b_ready),
        .i_ar(ar), .i_ar_valid(ar_valid), .o_ar_ready(o_ar_ready),
        .o_r(o_r), .o_r_valid(o_r_valid), .i_r_ready(r_ready),
        .o_ram_rd_en(o_ram_rd_en), .o_ram_addr(o_ram_addr), .i_ram_rdata(i_ram_rdata),
        .o_ram_wr_en(o_ram_wr_en), .o_ram_waddr(o_ram_waddr),
        .o_ram_wdata(o_ram_wdata), .o_ram_wmask(o_ram_wmask), .o_timer_irq(o_timer_irq)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // unwritten words read back a pattern of the full address
    function automatic logic [63:0] fill_word(input logic [63:0] a);
        return {a[31:0] ^ 32'h5a3c_96e1, a[63:32] ^ ~a[31:0]};
    endfunction

    function automatic logic [63:0] ram_word(input logic [63:0] a);
        if (tag_ok[a[10:3]] && tag[a[10:3]] == a)
            return mem[a[10:3]];
        return fill_word(a);
    endfunction

    function automatic logic [63:0] merge(input logic [63:0] old_val, new_val,
                                          input logic [7:0] strb);
        logic [63:0] res;
        res = old_val;
        for (int i = 0; i < 8; i++)
            if (strb[i])
                res[i*8 +: 8] = new_val[i*8 +: 8];
        return res;
    endfunction

    assign i_ram_rdata = ram_word(o_ram_addr);

    always @(posedge clk) begin
        if (o_ram_wr_en) begin
            mem[o_ram_waddr[10:3]] <= merge(ram_word(o_ram_waddr), o_ram_wdata, o_ram_wmask);
            tag[o_ram_waddr[10:3]] <= o_ram_waddr;
            tag_ok[o_ram_waddr[10:3]] <= 1'b1;
            wr_pulses <= wr_pulses + 1;
        end
        if (o_ram_rd_en)
            rd_pulses <= rd_pulses + 1;
    end

    // fibonacci lfsr with taps 32 22 2 1 and one step per bit
    function automatic logic [63:0] get_rand(input int nbits);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v = {v[62:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic flag_error(input string msg);
        $display("** Error at %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic check_eq(input logic [63:0] got, expv, input string what);
        assert (got == expv)
        else flag_error($sformatf("%s: got %h, expected %h", what, got, expv));
    endtask

    task automatic give_up(input string what);
        $display("run stopped, timed out waiting for %s", what);
        $display("Verification failed");
        $finish;
    endtask

    task automatic end_test(input string name, input int errs_before);
        tests++;
        if (errors != errs_before)
            failed++;
        $display("test %-12s %s", name, (errors == errs_before) ? "ok" : "FAILED");
    endtask

    task automatic axi_write(input logic [63:0] addr, data, input logic [7:0] strb,
                             input int stall, output logic [1:0] resp);
        int n;
        @(posedge clk);
        aw <= '{addr: addr};
        w <= '{data: data, strb: strb};
        aw_valid <= 1'b1;
        w_valid <= 1'b1;
        b_ready <= (stall == 0);
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > TMO)
                give_up("write acceptance");
        end while (!o_aw_ready);
        @(posedge clk);
        aw_valid <= 1'b0;
        w_valid <= 1'b0;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > TMO)
                give_up("write response");
        end while (!o_b_valid);
        if (stall > 0) begin
            // a read offered meanwhile has to wait behind the held response
            @(posedge clk);
            ar_valid <= 1'b1;
            repeat (stall) @(posedge clk);
            ar_valid <= 1'b0;
            b_ready <= 1'b1;
            @(negedge clk);
        end
        resp = o_b.resp;
        @(posedge clk);
    endtask

    task automatic axi_read(input logic [63:0] addr, input int stall,
                            output logic [63:0] data, output logic [1:0] resp);
        int n;
        @(posedge clk);
        ar <= '{addr: addr};
        ar_valid <= 1'b1;
        r_ready <= (stall == 0);
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > TMO)
                give_up("read acceptance");
        end while (!o_ar_ready);
        @(posedge clk);
        ar_valid <= 1'b0;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > TMO)
                give_up("read response");
        end while (!o_r_valid);
        if (stall > 0) begin
            // a write offered meanwhile has to wait behind the held response
            @(posedge clk);
            aw_valid <= 1'b1;
            w_valid <= 1'b1;
            repeat (stall) @(posedge clk);
            aw_valid <= 1'b0;
            w_valid <= 1'b0;
            r_ready <= 1'b1;
            @(negedge clk);
        end
        data = o_r.data;
        resp = o_r.resp;
        @(posedge clk);
    endtask

    a_reset_state: assert property (@(posedge clk) $rose(i_rst_n) |->
        !o_aw_ready && !o_w_ready && !o_ar_ready && !o_b_valid && !o_r_valid &&
        !o_ram_rd_en && !o_ram_wr_en && !o_timer_irq)
        else flag_error("outputs not idle after reset");

    a_ram_wr: assert property (@(posedge clk) disable iff (!i_rst_n) o_ram_wr_en |->
        o_ram_waddr == exp_addr && o_ram_wdata == exp_data && o_ram_wmask == exp_strb)
        else flag_error("ram write port does not match the bus write");

    a_ram_rd: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_ram_rd_en |-> o_ram_addr == exp_addr)
        else flag_error("ram read address does not match the bus read");

    a_no_ram: assert property (@(posedge clk) disable iff (!i_rst_n)
        no_ram |-> !o_ram_rd_en && !o_ram_wr_en)
        else flag_error("ram strobe on an unmapped access");

    // the response holds and nothing is accepted meanwhile
    a_b_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_b_valid && !b_ready |=> o_b_valid && $stable(o_b) &&
        !o_aw_ready && !o_w_ready && !o_ar_ready)
        else flag_error("write response not held under back-pressure");

    a_r_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_r_valid && !r_ready |=> o_r_valid && $stable(o_r) &&
        !o_aw_ready && !o_w_ready && !o_ar_ready)
        else flag_error("read response not held under back-pressure");

    a_b_lat: assert property (@(posedge clk) disable iff (!i_rst_n)
        aw_valid && o_aw_ready |=> !o_b_valid ##1 !o_b_valid ##1 o_b_valid)
        else flag_error("BVALID not exactly 3 cycles after acceptance");

    a_r_lat: assert property (@(posedge clk) disable iff (!i_rst_n)
        ar_valid && o_ar_ready |=> !o_r_valid ##1 !o_r_valid ##1 o_r_valid)
        else flag_error("RVALID not exactly 3 cycles after acceptance");

    initial begin
        logic [63:0] a, d, rd, t0, t1, v;
        logic [1:0] resp;
        int e, n, pulses, stall;
        lfsr = 32'hc539_a78b;
        errors = 0;
        tests = 0;
        failed = 0;
        wr_pulses = 0;
        rd_pulses = 0;
        tag_ok = '0;
        no_ram = 1'b0;
        exp_addr = '0;
        exp_data = '0;
        exp_strb = '0;
        i_rst_n = 1'b0;
        aw = '0;
        w = '0;
        ar = '0;
        aw_valid = 1'b0;
        w_valid = 1'b0;
        ar_valid = 1'b0;
        b_ready = 1'b1;
        r_ready = 1'b1;

        e = errors;
        repeat (3) @(posedge clk);
        i_rst_n <= 1'b1;
        repeat (2) @(posedge clk);
        end_test("reset", e);

        e = errors;
        a = get_rand(24);
        a = soc_pkg::RAM_BASE + {a[39:0], 3'b000};
        d = get_rand(64);
        v = get_rand(8);
        exp_addr = a;
        exp_data = d;
        exp_strb = v[7:0];
        pulses = wr_pulses;
        axi_write(a, d, v[7:0], 0, resp);
        check_eq(resp, soc_pkg::RESP_OKAY, "ram write response");
        check_eq(wr_pulses - pulses, 1, "ram write pulse count");
        pulses = rd_pulses;
        axi_read(a, 0, rd, resp);
        check_eq(resp, soc_pkg::RESP_OKAY, "ram read response");
        check_eq(rd_pulses - pulses, 1, "ram read pulse count");
        check_eq(rd, merge(fill_word(a), d, v[7:0]), "ram read data");
        end_test("ram_rw", e);

        e = errors;
        no_ram = 1'b1;
        axi_write(64'h0000_0000_1000_0000, d, 8'hff, 0, resp);
        check_eq(resp, soc_pkg::RESP_DECERR, "unmapped write response");
        axi_read(64'h0000_0001_8000_0000, 0, rd, resp);
        check_eq(resp, soc_pkg::RESP_DECERR, "unmapped read response");
        check_eq(rd, 64'h0, "unmapped read data");
        no_ram = 1'b0;
        end_test("unmapped", e);

        e = errors;
        axi_read(soc_pkg::CLINT_BASE + soc_pkg::MTIME_OFS, 0, t0, resp);
        axi_read(soc_pkg::CLINT_BASE + soc_pkg::MTIME_OFS, 0, t1, resp);
        check_eq(resp, soc_pkg::RESP_OKAY, "mtime read response");
        assert (t1 > t0)
        else flag_error($sformatf("mtime not increasing: %h then %h", t0, t1));
        v = get_rand(64);
        axi_write(soc_pkg::CLINT_BASE + soc_pkg::MTIMECMP_OFS, v, 8'hff, 0, resp);
        check_eq(resp, soc_pkg::RESP_OKAY, "mtimecmp write response");
        axi_read(soc_pkg::CLINT_BASE + soc_pkg::MTIMECMP_OFS, 0, rd, resp);
        check_eq(rd, v, "mtimecmp read back");
        axi_read(soc_pkg::CLINT_BASE + 64'h8, 0, rd, resp);
        check_eq(resp, soc_pkg::RESP_SLVERR, "bad clint offset read");
        axi_write(soc_pkg::CLINT_BASE + 64'h8, v, 8'hff, 0, resp);
        check_eq(resp, soc_pkg::RESP_SLVERR, "bad clint offset write");
        end_test("clint_regs", e);

        e = errors;
        axi_read(soc_pkg::CLINT_BASE + soc_pkg::MTIME_OFS, 0, t0, resp);
        axi_write(soc_pkg::CLINT_BASE + soc_pkg::MTIMECMP_OFS, t0 + 200, 8'hff, 0, resp);
        @(negedge clk);
        assert (!o_timer_irq)
        else flag_error("timer irq high before mtimecmp is reached");
        n = 0;
        while (!o_timer_irq) begin
            @(negedge clk);
            n++;
            if (n > TMO)
                give_up("timer interrupt to rise");
        end
        axi_write(soc_pkg::CLINT_BASE + soc_pkg::MTIMECMP_OFS, '1, 8'hff, 0, resp);
        n = 0;
        while (o_timer_irq) begin
            @(negedge clk);
            n++;
            if (n > TMO)
                give_up("timer interrupt to fall");
        end
        end_test("timer_irq", e);

        e = errors;
        for (int i = 0; i < 4; i++) begin
            a = get_rand(24);
            a = soc_pkg::RAM_BASE + {a[39:0], 3'b000};
            d = get_rand(64);
            v = get_rand(3);
            stall = 1 + int'(v[2:0]);
            exp_addr = a;
            exp_data = d;
            exp_strb = 8'hff;
            axi_write(a, d, 8'hff, stall, resp);
            check_eq(resp, soc_pkg::RESP_OKAY, "stalled write response");
            v = get_rand(3);
            stall = 1 + int'(v[2:0]);
            axi_read(a, stall, rd, resp);
            check_eq(rd, d, "stalled read data");
        end
        end_test("backpressure", e);

        repeat (4) @(posedge clk);
        $display("tests: %0d, failed: %0d, errors: %0d", tests, failed, errors);
        if (errors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
src/soc_pkg.sv
src/soc_addr_decode.sv
src/clint_timer.sv
src/ram_port_bridge.sv
src/soc_resp_mux.sv
src/soc_top.sv
tb/tb_soc_top.sv

/* run.sh */
#!/bin/sh
# build with Verilator and run, status follows the testbench result
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_soc_top -f flist.f -o sim_tb \
    && ./obj_dir/sim_tb | awk '{ print } /Verification passed/ { ok = 1 } END { exit !ok }' \
    && echo "run.sh: simulation ok" \
    || { echo "run.sh: simulation FAILED"; exit 1; }
